// ==== include/mbox_params.svh ====
// Address map, bus codes and register field positions of the two-core mailbox
// Included by the RTL and by the testbench
`ifndef MBOX_PARAMS_SVH
`define MBOX_PARAMS_SVH

// Mailbox window in the shared map
`define MBOX_BASE       32'h4003_0000
`define MBOX_ADDR_MASK  32'hFFFF_FF00  // Upper address bits that select the window

// Register offsets inside the window
// TX is the core's own outgoing channel
// RX is its incoming one
`define OFS_ACISR       8'h00  // Interrupt status and clear
`define OFS_TX_CTRL     8'h08
`define OFS_TX_DATA     8'h0C  // Write only
`define OFS_TX_STATUS   8'h10
`define OFS_RX_DATA     8'h18  // Read only
`define OFS_RX_STATUS   8'h1C

// AHB transfer types
`define HTRANS_IDLE     2'b00
`define HTRANS_BUSY     2'b01
`define HTRANS_NONSEQ   2'b10
`define HTRANS_SEQ      2'b11  // No bursts here

// AHB access sizes
`define HSIZE_BYTE      3'b000
`define HSIZE_HALF      3'b001
`define HSIZE_WORD      3'b010

// Control register fields
`define CTRL_IE_BIT     31  // Interrupt enable
`define CTRL_LEN_MSB    28
`define CTRL_LEN_LSB    15

// Status register fields
`define STAT_FULL_BIT   0   // Channel not empty
`define STAT_IRQ_BIT    1
`define STAT_CNT_MSB    29  // Remaining word count
`define STAT_CNT_LSB    16

// Written to ACISR by the receiver to release the channel
`define CLEAR_INT_CMD   32'h0000_4000

`endif

// ==== verilog/mbox_pkg.sv ====
// Shared types of the mailbox RTL and testbench
// Referenced by scoped name from each user

package mbox_pkg;

    // Bus data word
    typedef logic [31:0] mbox_word_t;

    // Bus address
    typedef logic [31:0] mbox_addr_t;

    // Message length and remaining count
    typedef logic [13:0] mbox_len_t;

    // AHB transfer type
    typedef logic [1:0] htrans_t;

    // AHB access size
    typedef logic [2:0] hsize_t;

    // One-word channel states
    typedef enum logic [1:0] {
        CH_IDLE     = 2'd0,  // Empty, accepts a push
        CH_FULL     = 2'd1,  // Word waiting for the receiver
        CH_READ_END = 2'd2   // Popped, waiting for the clear
    } ch_state_t;

endpackage

// ==== verilog/mbox_channel.sv ====
// One direction of the mailbox with a single word buffer
// Sender loads control and pushes, receiver pops then clears
`timescale 1ns/1ps
`include "mbox_params.svh"

module mbox_channel (
    input  logic                 hclk,
    input  logic                 hrst_b,
    input  logic                 ctrl_wr,    // Sender writes TX_CTRL
    input  logic                 data_wr,    // Sender pushes TX_DATA
    input  logic                 data_rd,    // Receiver reads RX_DATA
    input  logic                 clear_req,  // Receiver wrote the clear command
    input  mbox_pkg::mbox_word_t wdata,      // Size-masked write data
    output mbox_pkg::mbox_word_t ctrl,
    output mbox_pkg::mbox_word_t data,
    output mbox_pkg::mbox_word_t status,
    output logic                 irq,        // To the receiving core
    output logic                 push_err    // Push refused
);

    logic                 ie_q;     // Interrupt enable
    mbox_pkg::mbox_len_t  len_q;    // Programmed message length
    mbox_pkg::mbox_len_t  cnt_q;    // Words still to send
    mbox_pkg::mbox_word_t data_q;   // Buffered word
    mbox_pkg::ch_state_t  state_q;
    logic                 busy;
    logic                 push_ok;

    assign busy     = (state_q != mbox_pkg::CH_IDLE);
    assign push_ok  = data_wr && !busy;   // Only an empty channel takes a word
    assign push_err = data_wr && busy;    // Seen by the sender in the same data phase
    assign irq      = busy && ie_q;

    // Control register
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            ie_q  <= 1'b0;
            len_q <= '0;
        end
        else if (ctrl_wr) begin
            ie_q  <= wdata[`CTRL_IE_BIT];
            len_q <= wdata[`CTRL_LEN_MSB:`CTRL_LEN_LSB];
        end
    end

    // Remaining count
    // Reloaded by every control write
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            cnt_q <= '0;
        end
        else if (ctrl_wr) begin
            cnt_q <= wdata[`CTRL_LEN_MSB:`CTRL_LEN_LSB];
        end
        else if (push_ok && (cnt_q != '0)) begin
            cnt_q <= cnt_q - mbox_pkg::mbox_len_t'(1);  // Saturates at zero
        end
    end

    // Payload word
    always_ff @(posedge hclk) begin
        if (push_ok) begin
            data_q <= wdata;
        end
    end

    // Channel FSM
    // One push per interrupt, released by the clear
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            state_q <= mbox_pkg::CH_IDLE;
        end
        else begin
            case (state_q)
                mbox_pkg::CH_IDLE: begin
                    if (data_wr) begin
                        state_q <= mbox_pkg::CH_FULL;
                    end
                end
                mbox_pkg::CH_FULL: begin
                    if (data_rd) begin
                        state_q <= mbox_pkg::CH_READ_END;  // Receiver has the word
                    end
                end
                mbox_pkg::CH_READ_END: begin
                    if (clear_req) begin
                        state_q <= mbox_pkg::CH_IDLE;
                    end
                end
                default: begin
                    state_q <= mbox_pkg::CH_IDLE;
                end
            endcase
        end
    end

    // Control readback
    // Unused bits read as zero
    always_comb begin
        ctrl                              = '0;
        ctrl[`CTRL_IE_BIT]                = ie_q;
        ctrl[`CTRL_LEN_MSB:`CTRL_LEN_LSB] = len_q;
    end

    // Status word
    always_comb begin
        status                              = '0;
        status[`STAT_FULL_BIT]              = busy;
        status[`STAT_IRQ_BIT]               = irq;
        status[`STAT_CNT_MSB:`STAT_CNT_LSB] = cnt_q;
    end

    assign data = data_q;  // Stale after the pop until the next push

endmodule

// ==== verilog/mbox_ahb_port.sv ====
// AHB-Lite slave for one core of the mailbox
// Turns bus accesses into channel strobes and forms read data and response
`timescale 1ns/1ps
`include "mbox_params.svh"

module mbox_ahb_port (
    input  logic                 hclk,
    input  logic                 hrst_b,
    input  logic                 hsel,
    input  mbox_pkg::mbox_addr_t haddr,
    input  logic                 hwrite,
    input  mbox_pkg::htrans_t    htrans,
    input  mbox_pkg::hsize_t     hsize,
    input  mbox_pkg::mbox_word_t hwdata,
    output mbox_pkg::mbox_word_t hrdata,
    output logic                 hready,
    output logic                 hresp,        // 1 is ERROR
    output logic                 tx_ctrl_wr,   // To outgoing channel
    output logic                 tx_data_wr,
    output logic                 rx_data_rd,   // To incoming channel
    output logic                 rx_clear,
    output mbox_pkg::mbox_word_t wdata,        // Masked write data
    input  mbox_pkg::mbox_word_t tx_ctrl,
    input  mbox_pkg::mbox_word_t tx_status,
    input  mbox_pkg::mbox_word_t rx_data,
    input  mbox_pkg::mbox_word_t rx_status,
    input  logic                 tx_push_err,
    input  logic                 rx_irq,       // Own interrupt
    input  logic                 tx_irq        // Peer's interrupt
);

    // Address phase qualification
    logic                 take_a;
    logic                 seq_a;
    // Registered address phase
    logic                 act_q;   // NONSEQ access in data phase
    logic                 seq_q;   // SEQ access in data phase
    logic                 write_q;
    mbox_pkg::mbox_addr_t addr_q;
    mbox_pkg::hsize_t     size_q;
    // Data phase decode
    logic [7:0]           ofs;
    logic                 base_hit;
    logic                 hit_acisr;
    logic                 hit_tx_ctrl;
    logic                 hit_tx_data;
    logic                 hit_tx_status;
    logic                 hit_rx_data;
    logic                 hit_rx_status;
    logic                 mapped;
    logic                 ro_wr;
    logic                 wo_rd;
    logic                 dec_err;
    mbox_pkg::mbox_word_t acisr_rd;

    assign hready = 1'b1;  // Zero wait states

    always_comb begin
        take_a = 1'b0;
        seq_a  = 1'b0;
        case (htrans)
            `HTRANS_IDLE,
            `HTRANS_BUSY:   take_a = 1'b0;  // OKAY and no effect
            `HTRANS_NONSEQ: take_a = hsel;
            `HTRANS_SEQ:    seq_a  = hsel;  // Answered with ERROR
            default:        take_a = 1'b0;
        endcase
    end

    // Valid flags
    always_ff @(posedge hclk) begin
        if (!hrst_b) begin
            act_q <= 1'b0;
            seq_q <= 1'b0;
        end
        else begin
            act_q <= take_a;
            seq_q <= seq_a;
        end
    end

    // Address phase payload
    always_ff @(posedge hclk) begin
        write_q <= hwrite;
        addr_q  <= haddr;
        size_q  <= hsize;
    end

    assign ofs      = addr_q[7:0];
    assign base_hit = ((addr_q & `MBOX_ADDR_MASK) == `MBOX_BASE);

    assign hit_acisr     = base_hit && (ofs == `OFS_ACISR);
    assign hit_tx_ctrl   = base_hit && (ofs == `OFS_TX_CTRL);
    assign hit_tx_data   = base_hit && (ofs == `OFS_TX_DATA);
    assign hit_tx_status = base_hit && (ofs == `OFS_TX_STATUS);
    assign hit_rx_data   = base_hit && (ofs == `OFS_RX_DATA);
    assign hit_rx_status = base_hit && (ofs == `OFS_RX_STATUS);
    assign mapped        = hit_acisr || hit_tx_ctrl || hit_tx_data ||
                           hit_tx_status || hit_rx_data || hit_rx_status;

    // Illegal directions
    assign ro_wr   = write_q && (hit_tx_status || hit_rx_data || hit_rx_status);
    assign wo_rd   = !write_q && hit_tx_data;
    assign dec_err = seq_q || (act_q && (!mapped || ro_wr || wo_rd));

    // Push refusal comes back from the channel in the same cycle
    assign hresp = dec_err || tx_push_err;

    // Narrow writes take the low lanes
    always_comb begin
        case (size_q)
            `HSIZE_BYTE: wdata = {24'b0, hwdata[7:0]};
            `HSIZE_HALF: wdata = {16'b0, hwdata[15:0]};
            `HSIZE_WORD: wdata = hwdata;
            default:     wdata = '0;  // Wider than the bus
        endcase
    end

    // Single-cycle channel strobes
    assign tx_ctrl_wr = act_q && write_q && hit_tx_ctrl;
    assign tx_data_wr = act_q && write_q && hit_tx_data;
    assign rx_data_rd = act_q && !write_q && hit_rx_data;
    assign rx_clear   = act_q && write_q && hit_acisr && (wdata == `CLEAR_INT_CMD);

    // Own irq in bit 0 and the peer's in bit 1
    assign acisr_rd = {30'b0, tx_irq, rx_irq};

    // Read mux
    always_comb begin
        hrdata = '0;
        if (act_q && !write_q && base_hit) begin
            case (ofs)
                `OFS_ACISR:     hrdata = acisr_rd;
                `OFS_TX_CTRL:   hrdata = tx_ctrl;
                `OFS_TX_STATUS: hrdata = tx_status;
                `OFS_RX_DATA:   hrdata = rx_data;
                `OFS_RX_STATUS: hrdata = rx_status;
                default:        hrdata = '0;  // TX_DATA and holes
            endcase
        end
    end

endmodule

// ==== verilog/mbox_top.sv ====
// Two-core mailbox top with one AHB-Lite port per core
// Channel 0 runs core 0 to core 1 and channel 1 runs core 1 to core 0
`timescale 1ns/1ps

module mbox_top (
    input  logic                 hclk,
    input  logic                 hrst_b,
    // Core 0 bus
    input  logic                 c0_hsel,
    input  mbox_pkg::mbox_addr_t c0_haddr,
    input  logic                 c0_hwrite,
    input  mbox_pkg::htrans_t    c0_htrans,
    input  mbox_pkg::hsize_t     c0_hsize,
    input  mbox_pkg::mbox_word_t c0_hwdata,
    output mbox_pkg::mbox_word_t c0_hrdata,
    output logic                 c0_hready,
    output logic                 c0_hresp,
    // Core 1 bus
    input  logic                 c1_hsel,
    input  mbox_pkg::mbox_addr_t c1_haddr,
    input  logic                 c1_hwrite,
    input  mbox_pkg::htrans_t    c1_htrans,
    input  mbox_pkg::hsize_t     c1_hsize,
    input  mbox_pkg::mbox_word_t c1_hwdata,
    output mbox_pkg::mbox_word_t c1_hrdata,
    output logic                 c1_hready,
    output logic                 c1_hresp,
    // Receive interrupts
    output logic                 c0_irq,
    output logic                 c1_irq
);

    // Channel 0 wires
    logic                 ch0_ctrl_wr;
    logic                 ch0_data_wr;
    logic                 ch0_data_rd;
    logic                 ch0_clear;
    mbox_pkg::mbox_word_t ch0_wdata;
    mbox_pkg::mbox_word_t ch0_ctrl;
    mbox_pkg::mbox_word_t ch0_data;
    mbox_pkg::mbox_word_t ch0_status;
    logic                 ch0_irq;
    logic                 ch0_push_err;
    // Channel 1 wires
    logic                 ch1_ctrl_wr;
    logic                 ch1_data_wr;
    logic                 ch1_data_rd;
    logic                 ch1_clear;
    mbox_pkg::mbox_word_t ch1_wdata;
    mbox_pkg::mbox_word_t ch1_ctrl;
    mbox_pkg::mbox_word_t ch1_data;
    mbox_pkg::mbox_word_t ch1_status;
    logic                 ch1_irq;
    logic                 ch1_push_err;

    assign c1_irq = ch0_irq;  // Core 1 receives on channel 0
    assign c0_irq = ch1_irq;

    // Core 0 sends on ch0 and receives on ch1
    mbox_ahb_port u_port0 (
        .hclk        (hclk),
        .hrst_b      (hrst_b),
        .hsel        (c0_hsel),
        .haddr       (c0_haddr),
        .hwrite      (c0_hwrite),
        .htrans      (c0_htrans),
        .hsize       (c0_hsize),
        .hwdata      (c0_hwdata),
        .hrdata      (c0_hrdata),
        .hready      (c0_hready),
        .hresp       (c0_hresp),
        .tx_ctrl_wr  (ch0_ctrl_wr),
        .tx_data_wr  (ch0_data_wr),
        .rx_data_rd  (ch1_data_rd),
        .rx_clear    (ch1_clear),
        .wdata       (ch0_wdata),
        .tx_ctrl     (ch0_ctrl),
        .tx_status   (ch0_status),
        .rx_data     (ch1_data),
        .rx_status   (ch1_status),
        .tx_push_err (ch0_push_err),
        .rx_irq      (ch1_irq),
        .tx_irq      (ch0_irq)
    );

    // Core 1 is the mirror image
    mbox_ahb_port u_port1 (
        .hclk        (hclk),
        .hrst_b      (hrst_b),
        .hsel        (c1_hsel),
        .haddr       (c1_haddr),
        .hwrite      (c1_hwrite),
        .htrans      (c1_htrans),
        .hsize       (c1_hsize),
        .hwdata      (c1_hwdata),
        .hrdata      (c1_hrdata),
        .hready      (c1_hready),
        .hresp       (c1_hresp),
        .tx_ctrl_wr  (ch1_ctrl_wr),
        .tx_data_wr  (ch1_data_wr),
        .rx_data_rd  (ch0_data_rd),
        .rx_clear    (ch0_clear),
        .wdata       (ch1_wdata),
        .tx_ctrl     (ch1_ctrl),
        .tx_status   (ch1_status),
        .rx_data     (ch0_data),
        .rx_status   (ch0_status),
        .tx_push_err (ch1_push_err),
        .rx_irq      (ch0_irq),
        .tx_irq      (ch1_irq)
    );

    mbox_channel u_ch0 (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .ctrl_wr   (ch0_ctrl_wr),
        .data_wr   (ch0_data_wr),
        .data_rd   (ch0_data_rd),
        .clear_req (ch0_clear),
        .wdata     (ch0_wdata),
        .ctrl      (ch0_ctrl),
        .data      (ch0_data),
        .status    (ch0_status),
        .irq       (ch0_irq),
        .push_err  (ch0_push_err)
    );

    mbox_channel u_ch1 (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .ctrl_wr   (ch1_ctrl_wr),
        .data_wr   (ch1_data_wr),
        .data_rd   (ch1_data_rd),
        .clear_req (ch1_clear),
        .wdata     (ch1_wdata),
        .ctrl      (ch1_ctrl),
        .data      (ch1_data),
        .status    (ch1_status),
        .irq       (ch1_irq),
        .push_err  (ch1_push_err)
    );

endmodule

// ==== bench/mbox_tb.sv ====
// Self-checking random testbench for the two-core mailbox
// Drives both AHB ports and checks reads, responses and irqs against a channel model
`timescale 1ns/1ps
`include "mbox_params.svh"

module mbox_tb;

    logic             hclk;
    logic             hrst_b;
    logic [1:0]       hsel;     // Index is the core
    logic [1:0]       hwrite;
    logic [1:0][31:0] haddr;
    logic [1:0][1:0]  htrans;
    logic [1:0][2:0]  hsize;
    logic [1:0][31:0] hwdata;
    wire  [1:0][31:0] hrdata;
    wire  [1:0]       hready;
    wire  [1:0]       hresp;
    wire  [1:0]       irq;
    integer           seed;
    // Channel model indexed by the sending core
    mbox_pkg::mbox_word_t m_ctrl [2];
    mbox_pkg::mbox_word_t m_word [2];
    mbox_pkg::ch_state_t  m_state [2];
    mbox_pkg::mbox_len_t  m_cnt [2];
    mbox_pkg::mbox_word_t rd;
    logic                 resp;
    logic                 ie;
    mbox_pkg::mbox_len_t  len;

    mbox_top dut (
        .hclk      (hclk),
        .hrst_b    (hrst_b),
        .c0_hsel   (hsel[0]),
        .c0_haddr  (haddr[0]),
        .c0_hwrite (hwrite[0]),
        .c0_htrans (htrans[0]),
        .c0_hsize  (hsize[0]),
        .c0_hwdata (hwdata[0]),
        .c0_hrdata (hrdata[0]),
        .c0_hready (hready[0]),
        .c0_hresp  (hresp[0]),
        .c1_hsel   (hsel[1]),
        .c1_haddr  (haddr[1]),
        .c1_hwrite (hwrite[1]),
        .c1_htrans (htrans[1]),
        .c1_hsize  (hsize[1]),
        .c1_hwdata (hwdata[1]),
        .c1_hrdata (hrdata[1]),
        .c1_hready (hready[1]),
        .c1_hresp  (hresp[1]),
        .c0_irq    (irq[0]),
        .c1_irq    (irq[1])
    );

    always #10 hclk = ~hclk;  // 20 ns period

    task automatic fail_stop;
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input mbox_pkg::mbox_word_t exp,
                              input mbox_pkg::mbox_word_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s expected %b actual %b", name, exp, act);
            fail_stop();
        end
    endtask

    task automatic check_len(input string name, input mbox_pkg::mbox_len_t exp,
                             input mbox_pkg::mbox_len_t act);
        if (act !== exp) begin
            $display("ERROR %s expected %0d actual %0d", name, exp, act);
            fail_stop();
        end
    endtask

    // One access with address phase then data phase
    // Result sampled mid data phase
    task automatic bus_xfer(input int core, input logic wr, input logic [7:0] ofs,
                            input logic [2:0] size, input logic [1:0] trans,
                            input mbox_pkg::mbox_word_t wd,
                            output mbox_pkg::mbox_word_t rdata, output logic err);
        @(negedge hclk);
        hsel[core]   = 1'b1;
        hwrite[core] = wr;
        haddr[core]  = `MBOX_BASE | {24'b0, ofs};
        htrans[core] = trans;
        hsize[core]  = size;
        @(negedge hclk);
        hsel[core]   = 1'b0;  // Bus goes idle behind the access
        htrans[core] = `HTRANS_IDLE;
        hwdata[core] = wd;
        #1;
        rdata = hrdata[core];
        err   = hresp[core];
    endtask

    // Narrow writes keep the low lanes only
    function automatic mbox_pkg::mbox_word_t size_mask(input logic [2:0] size,
                                                       input mbox_pkg::mbox_word_t w);
        case (size)
            `HSIZE_BYTE: return w & 32'h0000_00FF;
            `HSIZE_HALF: return w & 32'h0000_FFFF;
            default:     return w;
        endcase
    endfunction

    // Waits for the receiver irq of channel ch
    task automatic wait_irq(input int ch, input logic level);
        int n;
        n = 0;
        while (irq[ch ^ 1] !== level) begin
            if (n == 20) begin
                $display("Timeout: irq of channel %0d never reached %b", ch, level);
                fail_stop();
            end
            @(negedge hclk);
            n++;
        end
    endtask

    task automatic set_ctrl(input int ch, input logic ie_v, input mbox_pkg::mbox_len_t len_v);
        mbox_pkg::mbox_word_t w;
        w                                = '0;
        w[`CTRL_IE_BIT]                  = ie_v;
        w[`CTRL_LEN_MSB:`CTRL_LEN_LSB]   = len_v;
        bus_xfer(ch, 1'b1, `OFS_TX_CTRL, `HSIZE_WORD, `HTRANS_NONSEQ, w, rd, resp);
        check_bit("ctrl write resp", 1'b0, resp);
        m_ctrl[ch] = w;
        m_cnt[ch]  = len_v;  // Count reloads with the length
    endtask

    task automatic push(input int ch, input mbox_pkg::mbox_word_t w, input logic [2:0] size);
        bus_xfer(ch, 1'b1, `OFS_TX_DATA, size, `HTRANS_NONSEQ, w, rd, resp);
        if (m_state[ch] == mbox_pkg::CH_IDLE) begin
            check_bit("push resp", 1'b0, resp);
            m_word[ch]  = size_mask(size, w);
            m_state[ch] = mbox_pkg::CH_FULL;
            if (m_cnt[ch] != 0) begin
                m_cnt[ch] = m_cnt[ch] - 1;  // Stops at zero
            end
        end
        else begin
            check_bit("refused push resp", 1'b1, resp);  // Busy channel
        end
    endtask

    task automatic pop(input int ch);
        bus_xfer(ch ^ 1, 1'b0, `OFS_RX_DATA, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_bit("rx data resp", 1'b0, resp);
        check_word("rx data", m_word[ch], rd);
        if (m_state[ch] == mbox_pkg::CH_FULL) begin
            m_state[ch] = mbox_pkg::CH_READ_END;
        end
    endtask

    task automatic clear(input int ch);
        bus_xfer(ch ^ 1, 1'b1, `OFS_ACISR, `HSIZE_WORD, `HTRANS_NONSEQ, `CLEAR_INT_CMD, rd, resp);
        check_bit("clear resp", 1'b0, resp);
        if (m_state[ch] == mbox_pkg::CH_READ_END) begin
            m_state[ch] = mbox_pkg::CH_IDLE;  // Early clear is ignored
        end
    endtask

    // irq pin plus status seen from both sides
    task automatic check_status(input int ch);
        mbox_pkg::mbox_word_t exp;
        logic                 exp_irq;
        exp_irq                         = (m_state[ch] != mbox_pkg::CH_IDLE) &&
                                          m_ctrl[ch][`CTRL_IE_BIT];
        exp                             = '0;
        exp[`STAT_FULL_BIT]             = (m_state[ch] != mbox_pkg::CH_IDLE);
        exp[`STAT_IRQ_BIT]              = exp_irq;
        exp[`STAT_CNT_MSB:`STAT_CNT_LSB] = m_cnt[ch];
        @(negedge hclk);  // Let the last write land
        check_bit("irq pin", exp_irq, irq[ch ^ 1]);
        bus_xfer(ch, 1'b0, `OFS_TX_STATUS, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_bit("tx status resp", 1'b0, resp);
        check_word("tx status", exp, rd);
        bus_xfer(ch ^ 1, 1'b0, `OFS_RX_STATUS, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_bit("rx status resp", 1'b0, resp);
        check_word("rx status", exp, rd);
    endtask

    // Random-length message on the channels set in dirs with interleaved accesses
    task automatic run_message(input logic [1:0] dirs);
        mbox_pkg::mbox_len_t n;
        logic [2:0]          size;
        n = 14'd1 + mbox_pkg::mbox_len_t'($unsigned($random(seed)) % 6);
        for (int ch = 0; ch < 2; ch++) begin
            if (dirs[ch]) begin
                set_ctrl(ch, 1'b1, n);
            end
        end
        for (int i = 0; i < n; i++) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (dirs[ch]) begin
                    size = 3'($unsigned($random(seed)) % 3);
                    push(ch, $random(seed), size);
                end
            end
            for (int ch = 0; ch < 2; ch++) begin
                if (dirs[ch]) begin
                    wait_irq(ch, 1'b1);
                    pop(ch);
                    clear(ch);
                    wait_irq(ch, 1'b0);  // Clear releases the channel
                end
            end
        end
        for (int ch = 0; ch < 2; ch++) begin
            if (dirs[ch]) begin
                check_status(ch);
                check_len("final count", '0, rd[`STAT_CNT_MSB:`STAT_CNT_LSB]);
            end
        end
    endtask

    initial begin
        seed   = 60536;
        hclk   = 1'b0;
        hrst_b = 1'b0;
        hsel   = '0;
        hwrite = '0;
        haddr  = '0;
        htrans = '0;
        hsize  = '0;
        hwdata = '0;
        for (int ch = 0; ch < 2; ch++) begin
            m_ctrl[ch]  = '0;
            m_word[ch]  = '0;
            m_state[ch] = mbox_pkg::CH_IDLE;
            m_cnt[ch]   = '0;
        end
        repeat (16) @(posedge hclk);
        @(negedge hclk);
        hrst_b = 1'b1;

        // Reset state
        check_bit("c0 irq after reset", 1'b0, irq[0]);
        check_bit("c1 irq after reset", 1'b0, irq[1]);
        check_bit("c0 hready", 1'b1, hready[0]);
        check_bit("c1 hready", 1'b1, hready[1]);
        check_status(0);
        check_status(1);

        // Control readback on both cores
        for (int c = 0; c < 2; c++) begin
            ie  = 1'($random(seed));
            len = mbox_pkg::mbox_len_t'($random(seed));
            set_ctrl(c, ie, len);
            bus_xfer(c, 1'b0, `OFS_TX_CTRL, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
            check_word("ctrl readback", m_ctrl[c], rd);
            check_status(c);
        end

        run_message(2'b01);  // Core 0 to core 1
        run_message(2'b11);  // Both directions

        // Second push before the clear is refused
        set_ctrl(0, 1'b1, 14'd3);
        push(0, $random(seed), `HSIZE_WORD);
        push(0, $random(seed), `HSIZE_WORD);
        wait_irq(0, 1'b1);
        pop(0);  // Still the first word
        clear(0);
        wait_irq(0, 1'b0);

        // Decode errors
        bus_xfer(0, 1'b0, 8'h04, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_bit("unmapped offset resp", 1'b1, resp);
        bus_xfer(1, 1'b0, `OFS_TX_CTRL, `HSIZE_WORD, `HTRANS_SEQ, '0, rd, resp);
        check_bit("seq resp", 1'b1, resp);
        bus_xfer(0, 1'b0, `OFS_TX_DATA, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_bit("tx data read resp", 1'b1, resp);

        // Clear before the pop leaves irq high
        set_ctrl(1, 1'b1, 14'd2);
        push(1, $random(seed), `HSIZE_HALF);
        wait_irq(1, 1'b1);
        clear(1);
        check_status(1);
        // Own irq in bit 0 and the peer's in bit 1
        bus_xfer(0, 1'b0, `OFS_ACISR, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_word("c0 acisr", 32'h0000_0001, rd);
        bus_xfer(1, 1'b0, `OFS_ACISR, `HSIZE_WORD, `HTRANS_NONSEQ, '0, rd, resp);
        check_word("c1 acisr", 32'h0000_0002, rd);
        pop(1);
        clear(1);
        wait_irq(1, 1'b0);

        // Interrupt disabled
        set_ctrl(1, 1'b0, 14'd2);
        push(1, $random(seed), `HSIZE_BYTE);
        check_status(1);  // Full but no irq
        pop(1);
        clear(1);
        check_status(1);

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
verilog/mbox_pkg.sv
verilog/mbox_channel.sv
verilog/mbox_ahb_port.sv
verilog/mbox_top.sv
bench/mbox_tb.sv

// ==== Bender.yml ====
package:
  name: mbox

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/mbox_pkg.sv
      - verilog/mbox_channel.sv
      - verilog/mbox_ahb_port.sv
      - verilog/mbox_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/mbox_tb.sv
